//--- cpu_golden.txt
// Cycle budget, program length and words, data length and words,
// store count with address/data pairs, then the halt PC
07E4    // budget in cycles, 48 * 40 + 100
0030    // program words
3200 3401 2E10 0650 47C0 0651 47C1 0652    // 00 loads, add, sub, and
47C2 0653 47C3 0654 47C4 0655 47C5 0656    // 08 or, xor, sll, srl
47C6 0657 47C7 3802 0B0F 4BC8 2C3D 1D87    // 10 slt, load use, li/addi chain
1DBF 4DC9 3403 148A 45CA 50C1 43CB 5141    // 18 load use, beqz taken/not
4BCC 6142 43CD 43CE 60C1 4DCF 2600 50C1    // 20 bnez taken/not, beqz after li
43D0 2814 191A 7100 43D1 43D2 49D3 F000    // 28 jr to 2E, halt at 2F
0004    // data words
1234 00F3 8001 0005
000E    // expected stores
0010 1327    // add
0011 1141    // sub
0012 0030    // and
0013 12F7    // or
0014 12C7    // xor
0015 91A0    // sll
0016 0246    // srl
0017 0000    // slt, not less
0018 0001    // slt, negative operand
0019 0003    // li and addi chain
001A 000F    // load then addi
001C 0001    // after beqz not taken
001F 0003    // after bnez not taken
0023 002E    // at jr target
002F    // halt PC

//--- list.f
+incdir+.
cpu_pkg.sv
alu.sv
reg_file.sv
if_stage.sv
id_stage.sv
exe_stage.sv
cpu_top.sv
tb_clock.sv
cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- cpu_tb.sv
`include "cpu_consts.svh"

module cpu_tb;
	logic                 clk;
	logic                 rst;
	logic                 imem_req;
	logic [`CPU_XLEN-1:0] imem_addr;
	logic                 imem_ack;
	logic [`CPU_XLEN-1:0] imem_rdata;
	logic                 dmem_req;
	logic                 dmem_we;
	logic [`CPU_XLEN-1:0] dmem_addr;
	logic [`CPU_XLEN-1:0] dmem_wdata;
	logic                 dmem_ack;
	logic [`CPU_XLEN-1:0] dmem_rdata;
	logic                 halted;

	logic [15:0] golden [128];
	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	integer      seed;
	logic [31:0] rnd;
	int          budget;
	int          store_count;
	int          store_base;
	int          stores_seen;
	int          cycles;
	logic [15:0] halt_pc;
	logic [15:0] last_fetch;

	tb_clock i_clock (
		.clk(clk),
		.rst(rst)
	);

	cpu_top i_dut (
		.clk(clk),
		.rst(rst),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_rdata(imem_rdata),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_ack(dmem_ack),
		.dmem_rdata(dmem_rdata),
		.halted(halted)
	);

	task automatic abort_run(input string why);
		$display("SIMULATION FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic load_golden();
		int prog_len;
		int data_len;
		int data_base;
		$readmemh("cpu_golden.txt", golden);
		budget = int'(golden[0]);
		prog_len = int'(golden[1]);
		data_len = int'(golden[7'(prog_len + 2)]);
		data_base = prog_len + 3;
		store_count = int'(golden[7'(data_base + data_len)]);
		store_base = data_base + data_len + 1;
		halt_pc = golden[7'(store_base + 2 * store_count)];
		for (int i = 0; i < 256; i++) begin
			// Unused code decodes as halt tagged with its address
			imem[i[7:0]] = {4'hf, 4'h0, i[7:0]};
			dmem[i[7:0]] = {~i[7:0], i[7:0]};
		end
		for (int i = 0; i < prog_len; i++) begin
			imem[i[7:0]] = golden[7'(i + 2)];
		end
		for (int i = 0; i < data_len; i++) begin
			dmem[i[7:0]] = golden[7'(data_base + i)];
		end
	endtask

	task automatic check_store(input logic [15:0] addr, input logic [15:0] data);
		int          idx;
		logic [15:0] exp_addr;
		logic [15:0] exp_data;
		assert (stores_seen < store_count) else begin
			$display("ERROR at %0t: extra store of %h to address %h", $time, data, addr);
			abort_run("more stores than expected");
		end
		idx = store_base + 2 * stores_seen;
		exp_addr = golden[7'(idx)];
		exp_data = golden[7'(idx + 1)];
		assert (addr == exp_addr && data == exp_data) else begin
			$display("ERROR at %0t: store %0d expected [%h] = %h, got [%h] = %h",
				$time, stores_seen, exp_addr, exp_data, addr, data);
			abort_run("store mismatch");
		end
		stores_seen++;
	endtask

	task automatic serve_imem();
		forever begin
			@(posedge clk);
			if (!rst && imem_req) begin
				assert (imem_addr[15:8] == 8'h00) else begin
					$display("Instruction fetch from %h is outside program memory", imem_addr);
					abort_run("fetch out of range");
				end
				last_fetch = imem_addr;
				repeat (rnd[2:0]) @(posedge clk);
				imem_ack <= 1'b1;
				imem_rdata <= imem[imem_addr[7:0]];
				do begin
					@(posedge clk);
				end while (imem_req);
				imem_ack <= 1'b0;
			end
		end
	endtask

	task automatic serve_dmem();
		forever begin
			@(posedge clk);
			if (!rst && dmem_req) begin
				assert (dmem_addr[15:8] == 8'h00) else begin
					$display("Data access at %h is outside data memory", dmem_addr);
					abort_run("data access out of range");
				end
				repeat (rnd[5:3]) @(posedge clk);
				if (dmem_we) begin
					check_store(dmem_addr, dmem_wdata);
					dmem[dmem_addr[7:0]] = dmem_wdata;
				end else begin
					dmem_rdata <= dmem[dmem_addr[7:0]];
				end
				dmem_ack <= 1'b1;
				do begin
					@(posedge clk);
				end while (dmem_req);
				dmem_ack <= 1'b0;
			end
		end
	endtask

	task automatic await_halt();
		do begin
			@(posedge clk);
		end while (rst || !halted);
		assert (stores_seen == store_count) else begin
			$display("ERROR at %0t: halted after %0d stores, expected %0d",
				$time, stores_seen, store_count);
			abort_run("store count at halt");
		end
		assert (last_fetch == halt_pc) else begin
			$display("ERROR at %0t: last fetch at %h, expected halt PC %h",
				$time, last_fetch, halt_pc);
			abort_run("halt PC");
		end
		// Fetch port must stay quiet once halted
		repeat (20) begin
			@(posedge clk);
			assert (!imem_req) else begin
				$display("Instruction fetch request seen after halt");
				abort_run("fetch after halt");
			end
		end
		if (stores_seen == store_count) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("Stores were seen after halt");
			abort_run("stores after halt");
		end
	endtask

	// One draw per cycle, imem and dmem take different bits
	always @(posedge clk) begin
		rnd <= $random(seed);
	end

	always @(posedge clk) begin
		if (!rst) begin
			cycles++;
			if (cycles >= budget) begin
				$display("Timeout after %0d cycles without a clean halt", cycles);
				abort_run("timeout");
			end
		end
	end

	initial begin
		seed = 4154;
		rnd = '0;
		cycles = 0;
		stores_seen = 0;
		last_fetch = '0;
		imem_ack = 1'b0;
		imem_rdata = '0;
		dmem_ack = 1'b0;
		dmem_rdata = '0;
		load_golden();
		fork
			serve_imem();
			serve_dmem();
			await_halt();
		join
	end

endmodule

//--- tb_clock.sv
module tb_clock (
	output logic clk,
	output logic rst
);
	// Period of 40
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- cpu_top.sv
`include "cpu_consts.svh"

module cpu_top import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	output logic                 imem_req,
	output logic [`CPU_XLEN-1:0] imem_addr,
	input  logic                 imem_ack,
	input  logic [`CPU_XLEN-1:0] imem_rdata,
	output logic                 dmem_req,
	output logic                 dmem_we,
	output logic [`CPU_XLEN-1:0] dmem_addr,
	output logic [`CPU_XLEN-1:0] dmem_wdata,
	input  logic                 dmem_ack,
	input  logic [`CPU_XLEN-1:0] dmem_rdata,
	output logic                 halted
);
	// IF to ID
	logic                 id_valid;
	logic [`CPU_XLEN-1:0] id_pc;
	instr_t               id_instr;
	logic                 stall;
	logic                 redirect;
	logic [`CPU_XLEN-1:0] redirect_pc;

	// Register reads
	logic [`CPU_RAW-1:0]  rs_addr;
	logic [`CPU_RAW-1:0]  rt_addr;
	logic [`CPU_XLEN-1:0] rs_data;
	logic [`CPU_XLEN-1:0] rt_data;

	// ID to EXE
	logic                 exe_valid;
	alu_op_t              exe_op;
	logic [`CPU_XLEN-1:0] exe_a;
	logic [`CPU_XLEN-1:0] exe_b;
	logic [`CPU_XLEN-1:0] exe_store_data;
	logic [`CPU_RAW-1:0]  exe_rd;
	logic                 exe_wen;
	logic                 exe_load;
	logic                 exe_store;
	logic                 exe_halt;
	logic [`CPU_RAW-1:0]  busy_rd;
	logic                 busy_wen;
	logic                 hold;

	// Write back
	logic                 wb_wen;
	logic [`CPU_RAW-1:0]  wb_rd;
	logic [`CPU_XLEN-1:0] wb_data;

	if_stage __if_stage (
		.clk(clk),
		.rst(rst),
		.hold(hold),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.halted(halted),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_rdata(imem_rdata),
		.id_valid(id_valid),
		.id_pc(id_pc),
		.id_instr(id_instr)
	);

	id_stage __id_stage (
		.clk(clk),
		.rst(rst),
		.hold(hold),
		.id_valid(id_valid),
		.id_pc(id_pc),
		.id_instr(id_instr),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.exe_busy_rd(busy_rd),
		.exe_busy_wen(busy_wen),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.exe_valid(exe_valid),
		.exe_op(exe_op),
		.exe_a(exe_a),
		.exe_b(exe_b),
		.exe_store_data(exe_store_data),
		.exe_rd(exe_rd),
		.exe_wen(exe_wen),
		.exe_load(exe_load),
		.exe_store(exe_store),
		.exe_halt(exe_halt)
	);

	reg_file __reg_file (
		.clk(clk),
		.rst(rst),
		.ra1(rs_addr),
		.rd1(rs_data),
		.ra2(rt_addr),
		.rd2(rt_data),
		.wen(wb_wen),
		.wa(wb_rd),
		.wd(wb_data)
	);

	exe_stage __exe_stage (
		.clk(clk),
		.rst(rst),
		.exe_valid(exe_valid),
		.exe_op(exe_op),
		.exe_a(exe_a),
		.exe_b(exe_b),
		.exe_store_data(exe_store_data),
		.exe_rd(exe_rd),
		.exe_wen(exe_wen),
		.exe_load(exe_load),
		.exe_store(exe_store),
		.exe_halt(exe_halt),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_ack(dmem_ack),
		.dmem_rdata(dmem_rdata),
		.hold(hold),
		.busy_rd(busy_rd),
		.busy_wen(busy_wen),
		.wb_wen(wb_wen),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.halted(halted)
	);

endmodule

//--- exe_stage.sv
`include "cpu_consts.svh"

module exe_stage import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 exe_valid,
	input  alu_op_t              exe_op,
	input  logic [`CPU_XLEN-1:0] exe_a,
	input  logic [`CPU_XLEN-1:0] exe_b,
	input  logic [`CPU_XLEN-1:0] exe_store_data,
	input  logic [`CPU_RAW-1:0]  exe_rd,
	input  logic                 exe_wen,
	input  logic                 exe_load,
	input  logic                 exe_store,
	input  logic                 exe_halt,
	output logic                 dmem_req,
	output logic                 dmem_we,
	output logic [`CPU_XLEN-1:0] dmem_addr,
	output logic [`CPU_XLEN-1:0] dmem_wdata,
	input  logic                 dmem_ack,
	input  logic [`CPU_XLEN-1:0] dmem_rdata,
	output logic                 hold,
	output logic [`CPU_RAW-1:0]  busy_rd,
	output logic                 busy_wen,
	output logic                 wb_wen,
	output logic [`CPU_RAW-1:0]  wb_rd,
	output logic [`CPU_XLEN-1:0] wb_data,
	output logic                 halted
);
	logic [`CPU_XLEN-1:0] alu_y;
	logic                 mem_op;
	logic                 mem_done;

	alu __alu (
		.op(exe_op),
		.a(exe_a),
		.b(exe_b),
		.y(alu_y),
		.zero()
	);

	assign mem_op = exe_valid && (exe_load || exe_store);
	assign mem_done = dmem_req && dmem_ack;
	// Whole pipeline frozen from EXE entry until the data ack
	assign hold = mem_op && !mem_done;

	assign dmem_addr = alu_y;
	assign dmem_wdata = exe_store_data;
	assign busy_rd = exe_rd;
	assign busy_wen = exe_valid && exe_wen;

	// Data port master
	always_ff @(posedge clk) begin
		if (rst) begin
			dmem_req <= 1'b0;
			dmem_we <= 1'b0;
		end else if (mem_done) begin
			dmem_req <= 1'b0;
			dmem_we <= 1'b0;
		end else if (mem_op && !dmem_req && !dmem_ack) begin
			dmem_req <= 1'b1;
			dmem_we <= exe_store;
		end
	end

	// EXE/WB register
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_wen <= 1'b0;
			halted <= 1'b0;
		end else if (!hold) begin
			wb_wen <= busy_wen;
			if (exe_valid && exe_halt) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			wb_rd <= exe_rd;
			wb_data <= exe_load ? dmem_rdata : alu_y;
		end
	end

	// Previous ack must fall before the next request
	assert property (@(posedge clk) disable iff (rst)
		!dmem_req && dmem_ack |=> !dmem_req);

endmodule

//--- id_stage.sv
`include "cpu_consts.svh"

module id_stage import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 hold,
	input  logic                 id_valid,
	input  logic [`CPU_XLEN-1:0] id_pc,
	input  instr_t               id_instr,
	output logic [`CPU_RAW-1:0]  rs_addr,
	output logic [`CPU_RAW-1:0]  rt_addr,
	input  logic [`CPU_XLEN-1:0] rs_data,
	input  logic [`CPU_XLEN-1:0] rt_data,
	input  logic [`CPU_RAW-1:0]  exe_busy_rd,
	input  logic                 exe_busy_wen,
	output logic                 stall,
	output logic                 redirect,
	output logic [`CPU_XLEN-1:0] redirect_pc,
	output logic                 exe_valid,
	output alu_op_t              exe_op,
	output logic [`CPU_XLEN-1:0] exe_a,
	output logic [`CPU_XLEN-1:0] exe_b,
	output logic [`CPU_XLEN-1:0] exe_store_data,
	output logic [`CPU_RAW-1:0]  exe_rd,
	output logic                 exe_wen,
	output logic                 exe_load,
	output logic                 exe_store,
	output logic                 exe_halt
);
	logic [3:0]           opcode;
	logic [`CPU_XLEN-1:0] imm;
	logic                 use_rs;
	logic                 use_rt;
	logic                 dec_wen;
	logic                 dec_load;
	logic                 dec_store;
	logic                 dec_halt;
	alu_op_t              dec_op;
	logic [`CPU_XLEN-1:0] dec_b;
	logic                 taken;

	assign opcode = id_instr.r.opcode;
	assign imm = {{(`CPU_XLEN-6){id_instr.i.imm[5]}}, id_instr.i.imm};
	assign rs_addr = id_instr.i.rs;
	// sw reads its data register through the rd field
	assign rt_addr = (opcode == `CPU_OP_SW) ? id_instr.i.rd : id_instr.r.rt;

	always_comb begin
		use_rs = 1'b0;
		use_rt = 1'b0;
		dec_wen = 1'b0;
		dec_load = 1'b0;
		dec_store = 1'b0;
		dec_halt = 1'b0;
		dec_op = alu_add;
		dec_b = imm;
		case (opcode)
			`CPU_OP_ALU: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				dec_wen = 1'b1;
				dec_op = alu_op_t'({1'b0, id_instr.r.funct});
				dec_b = rt_data;
			end
			`CPU_OP_ADDI: begin
				use_rs = 1'b1;
				dec_wen = 1'b1;
			end
			`CPU_OP_LI: begin
				dec_wen = 1'b1;
				dec_op = alu_pass_b;
			end
			`CPU_OP_LW: begin
				use_rs = 1'b1;
				dec_wen = 1'b1;
				dec_load = 1'b1;
			end
			`CPU_OP_SW: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				dec_store = 1'b1;
			end
			`CPU_OP_BEQZ, `CPU_OP_BNEZ, `CPU_OP_JR: begin
				use_rs = 1'b1;
			end
			`CPU_OP_HALT: begin
				dec_halt = 1'b1;
			end
			default: begin
				dec_op = alu_add;
			end
		endcase
	end

	// Branches and jumps resolve here against register data
	always_comb begin
		case (opcode)
			`CPU_OP_BEQZ: taken = (rs_data == '0);
			`CPU_OP_BNEZ: taken = (rs_data != '0);
			`CPU_OP_JR:   taken = 1'b1;
			default:      taken = 1'b0;
		endcase
	end

	assign redirect_pc = (opcode == `CPU_OP_JR) ? rs_data : id_pc + 1'b1 + imm;

	// RAW against the instruction now in EXE
	assign stall = id_valid && exe_busy_wen &&
		((use_rs && rs_addr == exe_busy_rd) || (use_rt && rt_addr == exe_busy_rd));
	assign redirect = id_valid && taken && !stall;

	// ID/EXE register, a stall leaves a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			exe_valid <= 1'b0;
		end else if (!hold) begin
			exe_valid <= id_valid && !stall;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			exe_op <= dec_op;
			exe_a <= rs_data;
			exe_b <= dec_b;
			exe_store_data <= rt_data;
			exe_rd <= id_instr.r.rd;
			exe_wen <= dec_wen;
			exe_load <= dec_load;
			exe_store <= dec_store;
			exe_halt <= dec_halt;
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(redirect && stall));

endmodule

//--- if_stage.sv
`include "cpu_consts.svh"

module if_stage import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 hold,
	input  logic                 stall,
	input  logic                 redirect,
	input  logic [`CPU_XLEN-1:0] redirect_pc,
	input  logic                 halted,
	output logic                 imem_req,
	output logic [`CPU_XLEN-1:0] imem_addr,
	input  logic                 imem_ack,
	input  logic [`CPU_XLEN-1:0] imem_rdata,
	output logic                 id_valid,
	output logic [`CPU_XLEN-1:0] id_pc,
	output instr_t               id_instr
);
	logic [`CPU_XLEN-1:0] pc;
	logic [`CPU_XLEN-1:0] target;
	logic                 squash;
	logic                 halt_seen;
	logic                 advance;
	logic                 redirect_take;
	logic                 fetch_take;
	logic                 fetch_start;
	logic                 word_ok;
	instr_t               fetched;

	assign fetched = imem_rdata;
	assign advance = !hold && !stall;
	assign redirect_take = redirect && advance;
	// A squashed fetch may retire even while the pipeline is frozen
	assign fetch_take = imem_req && imem_ack && (advance || squash);
	assign word_ok = fetch_take && !squash && !redirect_take;
	assign fetch_start = !imem_req && !imem_ack && !halted && !halt_seen;
	assign target = redirect_take ? redirect_pc : pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `CPU_RESET_PC;
			imem_req <= 1'b0;
			squash <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			if (fetch_take) begin
				imem_req <= 1'b0;
			end else if (fetch_start) begin
				imem_req <= 1'b1;
			end
			if (fetch_start) begin
				pc <= target + 1'b1;
			end else if (redirect_take) begin
				pc <= redirect_pc;
			end
			// Fetch still in flight when the branch leaves ID
			if (redirect_take) begin
				squash <= imem_req && !fetch_take;
			end else if (fetch_take) begin
				squash <= 1'b0;
			end
			if (word_ok && fetched.r.opcode == `CPU_OP_HALT) begin
				halt_seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_start) begin
			imem_addr <= target;
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid <= 1'b0;
		end else if (advance) begin
			id_valid <= word_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && fetch_take) begin
			id_pc <= imem_addr;
			id_instr <= fetched;
		end
	end

	// Req stays up until ack, address fixed meanwhile
	assert property (@(posedge clk) disable iff (rst)
		imem_req && !imem_ack |=> imem_req);
	assert property (@(posedge clk) disable iff (rst)
		imem_req |=> !imem_req || $stable(imem_addr));

endmodule

//--- reg_file.sv
`include "cpu_consts.svh"

module reg_file (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [`CPU_RAW-1:0]  ra1,
	output logic [`CPU_XLEN-1:0] rd1,
	input  logic [`CPU_RAW-1:0]  ra2,
	output logic [`CPU_XLEN-1:0] rd2,
	input  logic                 wen,
	input  logic [`CPU_RAW-1:0]  wa,
	input  logic [`CPU_XLEN-1:0] wd
);
	logic [`CPU_XLEN-1:0] regs [`CPU_NREG];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < `CPU_NREG; n++) begin
				regs[n] <= '0;
			end
		end else if (wen) begin
			regs[wa] <= wd;
		end
	end

	// Write-first, ID sees the WB value in the same cycle
	assign rd1 = (wen && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (wen && wa == ra2) ? wd : regs[ra2];

endmodule

//--- alu.sv
`include "cpu_consts.svh"

module alu import cpu_pkg::*; (
	input  alu_op_t              op,
	input  logic [`CPU_XLEN-1:0] a,
	input  logic [`CPU_XLEN-1:0] b,
	output logic [`CPU_XLEN-1:0] y,
	output logic                 zero
);
	logic [3:0] shamt;
	logic       less;

	assign shamt = b[3:0];
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_add: begin
				y = a + b;
			end
			alu_sub: begin
				y = a - b;
			end
			alu_and: begin
				y = a & b;
			end
			alu_or: begin
				y = a | b;
			end
			alu_xor: begin
				y = a ^ b;
			end
			alu_sll: begin
				y = a << shamt;
			end
			alu_srl: begin
				y = a >> shamt;
			end
			alu_slt: begin
				y = {{(`CPU_XLEN-1){1'b0}}, less};
			end
			alu_pass_b: begin
				y = b;
			end
			default: begin
				y = '0;
			end
		endcase
	end

	assign zero = (y == '0);

endmodule

//--- cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	// One fetched word, seen as R-type or as I-type
	typedef union packed {
		struct packed {
			logic [3:0]          opcode;
			logic [`CPU_RAW-1:0] rd;
			logic [`CPU_RAW-1:0] rs;
			logic [`CPU_RAW-1:0] rt;
			logic [2:0]          funct;
		} r;
		struct packed {
			logic [3:0]          opcode;
			logic [`CPU_RAW-1:0] rd;
			logic [`CPU_RAW-1:0] rs;
			logic signed [5:0]   imm;
		} i;
	} instr_t;

	// Low eight codes match the R-type funct field
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_sll    = 4'd5,
		alu_srl    = 4'd6,
		alu_slt    = 4'd7,
		alu_pass_b = 4'd8
	} alu_op_t;

endpackage

//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath sizes
`define CPU_XLEN      16
`define CPU_NREG      8
`define CPU_RAW       3

// Fetch starts here after reset
`define CPU_RESET_PC  16'h0000

// Opcodes in instruction bits 15 to 12
`define CPU_OP_ALU    4'h0
`define CPU_OP_ADDI   4'h1
`define CPU_OP_LI     4'h2
`define CPU_OP_LW     4'h3
`define CPU_OP_SW     4'h4
`define CPU_OP_BEQZ   4'h5
`define CPU_OP_BNEZ   4'h6
`define CPU_OP_JR     4'h7
`define CPU_OP_HALT   4'hf

`endif
